//--- source/vec_cfg_pkg.sv
// ----------------------------------------------------------
// sizing for a 32 element vector with two lanes per beat
// offsets carry one extra bit so -1 and vl itself fit
// ----------------------------------------------------------
`default_nettype none

package vec_cfg_pkg;

  localparam int unsigned VLMAX        = 32;
  localparam int unsigned ELEM_OFF_W   = 6;
  localparam int unsigned ELEM_IDX_W   = $clog2(VLMAX);
  localparam int unsigned XLEN         = 32;
  localparam int unsigned INIT_CREDITS = 4;

  typedef logic [ELEM_OFF_W-1:0] elem_off_t;
  typedef logic [ELEM_OFF_W-1:0] vl_t;
  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [4:0]            imm5_t;
  typedef logic [VLMAX-1:0]      mask_t;

  // enough bits to hold every credit, including the full count
  typedef logic [$clog2(INIT_CREDITS+1)-1:0] credit_t;

  // element width, 32 is the widest supported
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

endpackage

`default_nettype wire

//--- source/vec_uop_pkg.sv
// ----------------------------------------------------------
// offset modes are relative to the element index only
// ----------------------------------------------------------
`default_nettype none

package vec_uop_pkg;

  typedef enum logic [2:0] {
    VS2_SRC_NORMAL        = 3'd0,
    VS2_SRC_IDX_PLUS_RS1  = 3'd1,
    VS2_SRC_IDX_PLUS_UIMM = 3'd2,
    VS2_SRC_IDX_PLUS_1    = 3'd3,
    VS2_SRC_IDX_MINUS_1   = 3'd4,
    VS2_SRC_ZERO          = 3'd5
  } vs2_src_t;

  typedef enum logic [2:0] {
    VD_SRC_NORMAL        = 3'd0,
    VD_SRC_ZERO          = 3'd1,
    VD_SRC_IDX_PLUS_RS1  = 3'd2,
    VD_SRC_IDX_PLUS_UIMM = 3'd3,
    VD_SRC_IDX_PLUS_1    = 3'd4
  } vd_src_t;

  // element sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_RUN   = 2'd1,
    SEQ_DRAIN = 2'd2
  } seq_state_t;

endpackage

`default_nettype wire

//--- source/elem_sequencer.sv
// ----------------------------------------------------------
// walks elements two at a time from 0 to vl, one command
// at a time; command fields must hold until cmd_ready
// issue needs a credit, execute returns one per pulse
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module elem_sequencer (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  vec_cfg_pkg::vl_t       vl,
  input  logic                   credit_return,
  input  logic                   flush,
  output logic                   issue,
  output vec_cfg_pkg::elem_off_t elem_off,
  output logic                   last
);

  vec_uop_pkg::seq_state_t              state;
  vec_uop_pkg::seq_state_t              next_state;
  vec_cfg_pkg::credit_t                 credits;
  logic                                 accept;
  logic [vec_cfg_pkg::ELEM_OFF_W:0]     off_plus2;

  assign cmd_ready = (state == vec_uop_pkg::SEQ_IDLE);
  assign accept    = cmd_valid & cmd_ready;

  // a flushed beat is never issued, so it costs no credit
  assign issue = (state == vec_uop_pkg::SEQ_RUN) & (credits != '0) & ~flush;

  // extra bit keeps the compare right near the top of the range
  assign off_plus2 = elem_off + 2'd2;
  assign last      = (state == vec_uop_pkg::SEQ_RUN) & (off_plus2 >= {1'b0, vl});

  always_comb begin
    next_state = state;
    case (state)
      vec_uop_pkg::SEQ_IDLE: begin
        // empty command only burns the drain cycle
        if (accept) begin
          next_state = (vl == '0) ? vec_uop_pkg::SEQ_DRAIN : vec_uop_pkg::SEQ_RUN;
        end
      end
      vec_uop_pkg::SEQ_RUN: begin
        if (issue && last) begin
          next_state = vec_uop_pkg::SEQ_IDLE;
        end
      end
      default: next_state = vec_uop_pkg::SEQ_IDLE;
    endcase
    if (flush) begin
      next_state = vec_uop_pkg::SEQ_IDLE;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      // one dead cycle after reset before ready
      state    <= vec_uop_pkg::SEQ_DRAIN;
      elem_off <= '0;
      credits  <= vec_cfg_pkg::credit_t'(vec_cfg_pkg::INIT_CREDITS);
    end else begin
      state <= next_state;
      if (accept) begin
        elem_off <= '0;
      end else if (issue) begin
        elem_off <= elem_off + vec_cfg_pkg::elem_off_t'(2);
      end
      credits <= credits - {{($bits(credits)-1){1'b0}}, issue}
                         + {{($bits(credits)-1){1'b0}}, credit_return};
    end
  end

  // execute must never hand back more than it was given
  a_credit_max: assert property (@(posedge CLK) disable iff (!nRST)
    credits <= vec_cfg_pkg::INIT_CREDITS)
    else $error("credit count above initial value");

  // with no credit left and none coming back, the next cycle stays idle
  a_issue_credit: assert property (@(posedge CLK) disable iff (!nRST)
    (credits == '0) && !credit_return |=> !issue)
    else $error("beat issued without a credit");

endmodule

`default_nettype wire

//--- source/offset_gen.sv
// ----------------------------------------------------------
// element offsets for vs2 and vd on both lanes
// all sums wrap at the offset width
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module offset_gen (
  input  logic                   CLK,
  input  vec_cfg_pkg::elem_off_t elem_off,
  input  vec_uop_pkg::vs2_src_t  vs2_src,
  input  vec_uop_pkg::vd_src_t   vd_src,
  input  vec_cfg_pkg::xlen_t     xs1,
  input  vec_cfg_pkg::imm5_t     imm5,
  output vec_cfg_pkg::elem_off_t vs2_off0,
  output vec_cfg_pkg::elem_off_t vs2_off1,
  output vec_cfg_pkg::elem_off_t vd_off0,
  output vec_cfg_pkg::elem_off_t vd_off1
);

  vec_cfg_pkg::elem_off_t rs1_base;
  vec_cfg_pkg::elem_off_t uimm_base;
  vec_cfg_pkg::elem_off_t plus1;
  vec_cfg_pkg::elem_off_t plus2;
  vec_cfg_pkg::elem_off_t minus1;

  // shared terms for both selects
  assign rs1_base  = elem_off + vec_cfg_pkg::elem_off_t'(xs1);
  assign uimm_base = elem_off + vec_cfg_pkg::elem_off_t'(imm5);
  assign plus1     = elem_off + vec_cfg_pkg::elem_off_t'(1);
  assign plus2     = elem_off + vec_cfg_pkg::elem_off_t'(2);
  assign minus1    = elem_off - vec_cfg_pkg::elem_off_t'(1);

  always_comb begin
    case (vs2_src)
      vec_uop_pkg::VS2_SRC_NORMAL: begin
        vs2_off0 = elem_off;
        vs2_off1 = plus1;
      end
      vec_uop_pkg::VS2_SRC_IDX_PLUS_RS1: begin
        vs2_off0 = rs1_base;
        vs2_off1 = rs1_base + vec_cfg_pkg::elem_off_t'(1);
      end
      vec_uop_pkg::VS2_SRC_IDX_PLUS_UIMM: begin
        vs2_off0 = uimm_base;
        vs2_off1 = uimm_base + vec_cfg_pkg::elem_off_t'(1);
      end
      vec_uop_pkg::VS2_SRC_IDX_PLUS_1: begin
        vs2_off0 = plus1;
        vs2_off1 = plus2;
      end
      // slide down by one, lane 0 at element 0 wraps to all ones
      vec_uop_pkg::VS2_SRC_IDX_MINUS_1: begin
        vs2_off0 = minus1;
        vs2_off1 = elem_off;
      end
      default: begin
        vs2_off0 = '0;
        vs2_off1 = '0;
      end
    endcase
  end

  always_comb begin
    case (vd_src)
      vec_uop_pkg::VD_SRC_NORMAL: begin
        vd_off0 = elem_off;
        vd_off1 = plus1;
      end
      vec_uop_pkg::VD_SRC_IDX_PLUS_RS1: begin
        vd_off0 = rs1_base;
        vd_off1 = rs1_base + vec_cfg_pkg::elem_off_t'(1);
      end
      vec_uop_pkg::VD_SRC_IDX_PLUS_UIMM: begin
        vd_off0 = uimm_base;
        vd_off1 = uimm_base + vec_cfg_pkg::elem_off_t'(1);
      end
      vec_uop_pkg::VD_SRC_IDX_PLUS_1: begin
        vd_off0 = plus1;
        vd_off1 = plus2;
      end
      default: begin
        vd_off0 = '0;
        vd_off1 = '0;
      end
    endcase
  end

  // a new select from the caller must be one of the six modes
  a_vs2_src_legal: assert property (@(posedge CLK)
    $changed(vs2_src) |-> vs2_src inside {vec_uop_pkg::VS2_SRC_NORMAL,
      vec_uop_pkg::VS2_SRC_IDX_PLUS_RS1, vec_uop_pkg::VS2_SRC_IDX_PLUS_UIMM,
      vec_uop_pkg::VS2_SRC_IDX_PLUS_1, vec_uop_pkg::VS2_SRC_IDX_MINUS_1,
      vec_uop_pkg::VS2_SRC_ZERO})
    else $error("illegal vs2 source mode");

endmodule

`default_nettype wire

//--- source/width_calc.sv
// ----------------------------------------------------------
// destination and vs2 widths, saturating at SEW8 and SEW32
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module width_calc (
  input  logic              CLK,
  input  vec_cfg_pkg::sew_t sew,
  input  logic              widen,
  input  logic              widen_in,
  input  logic              narrow,
  output vec_cfg_pkg::sew_t eew,
  output vec_cfg_pkg::sew_t vs2_sew
);

  function automatic vec_cfg_pkg::sew_t step_up(input vec_cfg_pkg::sew_t w);
    return (w == vec_cfg_pkg::SEW8) ? vec_cfg_pkg::SEW16 : vec_cfg_pkg::SEW32;
  endfunction

  function automatic vec_cfg_pkg::sew_t step_down(input vec_cfg_pkg::sew_t w);
    return (w == vec_cfg_pkg::SEW32) ? vec_cfg_pkg::SEW16 : vec_cfg_pkg::SEW8;
  endfunction

  // widen wins if both were ever set
  assign eew = widen  ? step_up(sew)   :
               narrow ? step_down(sew) : sew;

  assign vs2_sew = widen_in ? step_up(sew) : sew;

  a_widen_narrow: assert property (@(posedge CLK) !(widen && narrow))
    else $error("widen and narrow both set");

endmodule

`default_nettype wire

//--- source/lane_enable.sv
// ----------------------------------------------------------
// lane write enables, bound by vl and optionally by v0
// vm high means the op is masked by v0
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lane_enable (
  input  vec_cfg_pkg::elem_off_t elem_off,
  input  vec_cfg_pkg::vl_t       vl,
  input  logic                   vm,
  input  vec_cfg_pkg::mask_t     v0_mask,
  output logic                   wen0,
  output logic                   wen1
);

  vec_cfg_pkg::elem_off_t                 elem1;
  logic [vec_cfg_pkg::ELEM_IDX_W-1:0]     idx0;
  logic [vec_cfg_pkg::ELEM_IDX_W-1:0]     idx1;

  // element index, not the shifted source offset
  assign elem1 = elem_off + vec_cfg_pkg::elem_off_t'(1);
  assign idx0  = elem_off[vec_cfg_pkg::ELEM_IDX_W-1:0];
  assign idx1  = elem1[vec_cfg_pkg::ELEM_IDX_W-1:0];

  assign wen0 = (elem_off < vl) & (~vm | v0_mask[idx0]);
  // odd vl turns lane 1 off on the final beat
  assign wen1 = (elem1 < vl) & (~vm | v0_mask[idx1]);

endmodule

`default_nettype wire

//--- source/issue_reg.sv
// ----------------------------------------------------------
// beat register toward execute; payload holds between beats
// flush drops the beat in flight
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module issue_reg (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   flush,
  input  logic                   issue,
  input  logic                   last,
  input  vec_cfg_pkg::elem_off_t vs2_off0,
  input  vec_cfg_pkg::elem_off_t vs2_off1,
  input  vec_cfg_pkg::elem_off_t vd_off0,
  input  vec_cfg_pkg::elem_off_t vd_off1,
  input  logic                   wen0,
  input  logic                   wen1,
  input  vec_cfg_pkg::sew_t      eew,
  input  vec_cfg_pkg::sew_t      vs2_sew,
  output logic                   uop_valid,
  output logic                   uop_last,
  output vec_cfg_pkg::elem_off_t uop_vs2_off0,
  output vec_cfg_pkg::elem_off_t uop_vs2_off1,
  output vec_cfg_pkg::elem_off_t uop_vd_off0,
  output vec_cfg_pkg::elem_off_t uop_vd_off1,
  output logic                   uop_wen0,
  output logic                   uop_wen1,
  output vec_cfg_pkg::sew_t      uop_eew,
  output vec_cfg_pkg::sew_t      uop_vs2_sew
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      uop_valid    <= 1'b0;
      uop_last     <= 1'b0;
      uop_vs2_off0 <= '0;
      uop_vs2_off1 <= '0;
      uop_vd_off0  <= '0;
      uop_vd_off1  <= '0;
      uop_wen0     <= 1'b0;
      uop_wen1     <= 1'b0;
      uop_eew      <= vec_cfg_pkg::SEW8;
      uop_vs2_sew  <= vec_cfg_pkg::SEW8;
    end else if (flush) begin
      uop_valid    <= 1'b0;
      uop_last     <= 1'b0;
      uop_vs2_off0 <= '0;
      uop_vs2_off1 <= '0;
      uop_vd_off0  <= '0;
      uop_vd_off1  <= '0;
      uop_wen0     <= 1'b0;
      uop_wen1     <= 1'b0;
      uop_eew      <= vec_cfg_pkg::SEW8;
      uop_vs2_sew  <= vec_cfg_pkg::SEW8;
    end else if (issue) begin
      uop_valid    <= 1'b1;
      uop_last     <= last;
      uop_vs2_off0 <= vs2_off0;
      uop_vs2_off1 <= vs2_off1;
      uop_vd_off0  <= vd_off0;
      uop_vd_off1  <= vd_off1;
      uop_wen0     <= wen0;
      uop_wen1     <= wen1;
      uop_eew      <= eew;
      uop_vs2_sew  <= vs2_sew;
    end else begin
      // last only means something alongside valid
      uop_valid <= 1'b0;
      uop_last  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/vec_decode_top.sv
// ----------------------------------------------------------
// vector element walker, one command in, two-lane beats out
// beats go out under credit flow control, see elem_sequencer
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module vec_decode_top (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  vec_uop_pkg::vs2_src_t  cmd_vs2_src,
  input  vec_uop_pkg::vd_src_t   cmd_vd_src,
  input  logic                   cmd_widen,
  input  logic                   cmd_widen_in,
  input  logic                   cmd_narrow,
  input  logic                   cmd_vm,
  input  vec_cfg_pkg::imm5_t     cmd_imm5,
  input  vec_cfg_pkg::xlen_t     cmd_xs1,
  input  vec_cfg_pkg::vl_t       cmd_vl,
  input  vec_cfg_pkg::sew_t      cmd_sew,
  input  vec_cfg_pkg::mask_t     v0_mask,
  input  logic                   credit_return,
  input  logic                   flush,
  output logic                   uop_valid,
  output logic                   uop_last,
  output vec_cfg_pkg::elem_off_t uop_vs2_off0,
  output vec_cfg_pkg::elem_off_t uop_vs2_off1,
  output vec_cfg_pkg::elem_off_t uop_vd_off0,
  output vec_cfg_pkg::elem_off_t uop_vd_off1,
  output logic                   uop_wen0,
  output logic                   uop_wen1,
  output vec_cfg_pkg::sew_t      uop_eew,
  output vec_cfg_pkg::sew_t      uop_vs2_sew
);

  logic                   issue;
  logic                   last;
  vec_cfg_pkg::elem_off_t elem_off;
  vec_cfg_pkg::elem_off_t vs2_off0;
  vec_cfg_pkg::elem_off_t vs2_off1;
  vec_cfg_pkg::elem_off_t vd_off0;
  vec_cfg_pkg::elem_off_t vd_off1;
  logic                   wen0;
  logic                   wen1;
  vec_cfg_pkg::sew_t      eew;
  vec_cfg_pkg::sew_t      vs2_sew;

  elem_sequencer u_seq (
    .CLK(CLK), .nRST(nRST), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .vl(cmd_vl), .credit_return(credit_return), .flush(flush),
    .issue(issue), .elem_off(elem_off), .last(last)
  );

  offset_gen u_offset (
    .CLK(CLK), .elem_off(elem_off), .vs2_src(cmd_vs2_src), .vd_src(cmd_vd_src),
    .xs1(cmd_xs1), .imm5(cmd_imm5), .vs2_off0(vs2_off0), .vs2_off1(vs2_off1),
    .vd_off0(vd_off0), .vd_off1(vd_off1)
  );

  width_calc u_width (
    .CLK(CLK), .sew(cmd_sew), .widen(cmd_widen), .widen_in(cmd_widen_in),
    .narrow(cmd_narrow), .eew(eew), .vs2_sew(vs2_sew)
  );

  lane_enable u_lane (
    .elem_off(elem_off), .vl(cmd_vl), .vm(cmd_vm), .v0_mask(v0_mask),
    .wen0(wen0), .wen1(wen1)
  );

  issue_reg u_issue (
    .CLK(CLK), .nRST(nRST), .flush(flush), .issue(issue), .last(last),
    .vs2_off0(vs2_off0), .vs2_off1(vs2_off1), .vd_off0(vd_off0), .vd_off1(vd_off1),
    .wen0(wen0), .wen1(wen1), .eew(eew), .vs2_sew(vs2_sew),
    .uop_valid(uop_valid), .uop_last(uop_last),
    .uop_vs2_off0(uop_vs2_off0), .uop_vs2_off1(uop_vs2_off1),
    .uop_vd_off0(uop_vd_off0), .uop_vd_off1(uop_vd_off1),
    .uop_wen0(uop_wen0), .uop_wen1(uop_wen1),
    .uop_eew(uop_eew), .uop_vs2_sew(uop_vs2_sew)
  );

endmodule

`default_nettype wire

//--- test/tb_vec_decode.sv
// ----------------------------------------------------------
// commands come from test/decode_vectors.txt, 12 words each
// credit delay ff draws a random delay of 0 to 7 per beat
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_vec_decode;

  localparam int NW         = 12;
  localparam int MAX_CMDS   = 64;
  localparam int RST_CYCLES = 16;
  localparam int RAND_MAX_D = 7;

  logic                   CLK;
  logic                   nRST;
  logic                   cmd_valid;
  logic                   cmd_ready;
  vec_uop_pkg::vs2_src_t  cmd_vs2_src;
  vec_uop_pkg::vd_src_t   cmd_vd_src;
  logic                   cmd_widen;
  logic                   cmd_widen_in;
  logic                   cmd_narrow;
  logic                   cmd_vm;
  vec_cfg_pkg::imm5_t     cmd_imm5;
  vec_cfg_pkg::xlen_t     cmd_xs1;
  vec_cfg_pkg::vl_t       cmd_vl;
  vec_cfg_pkg::sew_t      cmd_sew;
  vec_cfg_pkg::mask_t     v0_mask;
  logic                   credit_return;
  logic                   flush;
  logic                   uop_valid;
  logic                   uop_last;
  vec_cfg_pkg::elem_off_t uop_vs2_off0;
  vec_cfg_pkg::elem_off_t uop_vs2_off1;
  vec_cfg_pkg::elem_off_t uop_vd_off0;
  vec_cfg_pkg::elem_off_t uop_vd_off1;
  logic                   uop_wen0;
  logic                   uop_wen1;
  vec_cfg_pkg::sew_t      uop_eew;
  vec_cfg_pkg::sew_t      uop_vs2_sew;

  logic [31:0] vec_mem [0:MAX_CMDS*NW-1];
  int          n_cmds;
  int          errors;
  int          checks;
  int          cycle;
  int          limit;
  int          outstanding;
  int          cur_delay;
  logic        cur_random;
  integer      seed;
  int          due_q[$];
  int          q_idx;
  logic        q_found;
  int          ret_delay;

  vec_decode_top u_dut (.*);

  always #50 CLK = ~CLK;

  // expected offsets for element index e, straight from the mode table
  function automatic vec_cfg_pkg::elem_off_t vs2_exp(input int e);
    case (cmd_vs2_src)
      vec_uop_pkg::VS2_SRC_IDX_PLUS_RS1:  return vec_cfg_pkg::elem_off_t'(e + int'(cmd_xs1));
      vec_uop_pkg::VS2_SRC_IDX_PLUS_UIMM: return vec_cfg_pkg::elem_off_t'(e + int'(cmd_imm5));
      vec_uop_pkg::VS2_SRC_IDX_PLUS_1:    return vec_cfg_pkg::elem_off_t'(e + 1);
      vec_uop_pkg::VS2_SRC_IDX_MINUS_1:   return vec_cfg_pkg::elem_off_t'(e - 1);
      vec_uop_pkg::VS2_SRC_ZERO:          return '0;
      default:                            return vec_cfg_pkg::elem_off_t'(e);
    endcase
  endfunction

  function automatic vec_cfg_pkg::elem_off_t vd_exp(input int e);
    case (cmd_vd_src)
      vec_uop_pkg::VD_SRC_IDX_PLUS_RS1:  return vec_cfg_pkg::elem_off_t'(e + int'(cmd_xs1));
      vec_uop_pkg::VD_SRC_IDX_PLUS_UIMM: return vec_cfg_pkg::elem_off_t'(e + int'(cmd_imm5));
      vec_uop_pkg::VD_SRC_IDX_PLUS_1:    return vec_cfg_pkg::elem_off_t'(e + 1);
      vec_uop_pkg::VD_SRC_ZERO:          return '0;
      default:                           return vec_cfg_pkg::elem_off_t'(e);
    endcase
  endfunction

  // width in bits, one step up or down, clamped to 8..32
  function automatic vec_cfg_pkg::sew_t width_exp(input logic up, input logic down);
    int bits;
    bits = 8 << int'(cmd_sew);
    if (up) begin
      bits = (bits == 32) ? 32 : bits * 2;
    end else if (down) begin
      bits = (bits == 8) ? 8 : bits / 2;
    end
    if (bits == 8) begin
      return vec_cfg_pkg::SEW8;
    end
    return (bits == 16) ? vec_cfg_pkg::SEW16 : vec_cfg_pkg::SEW32;
  endfunction

  function automatic logic wen_exp(input int idx);
    return (idx < int'(cmd_vl)) && (!cmd_vm || v0_mask[idx]);
  endfunction

  // worst case cycles for one command line
  function automatic int run_budget(input int v);
    int d;
    int nb;
    d  = (vec_mem[v*NW+11][7:0] == 8'hff) ? RAND_MAX_D : int'(vec_mem[v*NW+11][7:0]);
    nb = (int'(vec_mem[v*NW+8][5:0]) + 1) / 2;
    return nb * (1 + d) + 4;
  endfunction

  task automatic report_failure(input string what);
    errors++;
    $display("%s at %0t ns", what, $time);
  endtask

  task automatic check_off(input string name, input vec_cfg_pkg::elem_off_t exp,
                           input vec_cfg_pkg::elem_off_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %h actual %h at %0t ns", name, exp, act, $time);
    end
  endtask

  task automatic check_sew(input string name, input vec_cfg_pkg::sew_t exp,
                           input vec_cfg_pkg::sew_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %h actual %h at %0t ns", name, exp, act, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %h actual %h at %0t ns", name, exp, act, $time);
    end
  endtask

  task automatic load_cmd(input int v);
    int b;
    b = v * NW;
    cmd_vs2_src  = vec_uop_pkg::vs2_src_t'(vec_mem[b][2:0]);
    cmd_vd_src   = vec_uop_pkg::vd_src_t'(vec_mem[b+1][2:0]);
    cmd_widen    = vec_mem[b+2][0];
    cmd_widen_in = vec_mem[b+3][0];
    cmd_narrow   = vec_mem[b+4][0];
    cmd_vm       = vec_mem[b+5][0];
    cmd_imm5     = vec_mem[b+6][4:0];
    cmd_xs1      = vec_mem[b+7];
    cmd_vl       = vec_mem[b+8][5:0];
    cmd_sew      = vec_cfg_pkg::sew_t'(vec_mem[b+9][1:0]);
    v0_mask      = vec_mem[b+10];
    cur_random   = (vec_mem[b+11][7:0] == 8'hff);
    cur_delay    = int'(vec_mem[b+11][7:0]);
  endtask

  // one command from the vector memory, flush_at < 0 runs it to the end
  task automatic run_cmd(input int v, input int flush_at);
    int k;
    int nb;
    int e;
    int err0;
    err0 = errors;
    k    = 0;
    while (!cmd_ready) @(negedge CLK);
    @(posedge CLK);
    #5;
    load_cmd(v);
    cmd_valid = 1'b1;
    nb = (int'(cmd_vl) + 1) / 2;
    @(posedge CLK);
    #5;
    cmd_valid = 1'b0;
    do begin
      @(negedge CLK);
      if (uop_valid) begin
        if (k >= nb) begin
          report_failure("beat seen after the final beat of the command");
        end else begin
          e = 2 * k;
          check_off("uop_vs2_off0", vs2_exp(e), uop_vs2_off0);
          check_off("uop_vs2_off1", vs2_exp(e + 1), uop_vs2_off1);
          check_off("uop_vd_off0", vd_exp(e), uop_vd_off0);
          check_off("uop_vd_off1", vd_exp(e + 1), uop_vd_off1);
          check_bit("uop_wen0", wen_exp(e), uop_wen0);
          check_bit("uop_wen1", wen_exp(e + 1), uop_wen1);
          check_bit("uop_last", k == nb - 1, uop_last);
          check_sew("uop_eew", width_exp(cmd_widen, cmd_narrow), uop_eew);
          check_sew("uop_vs2_sew", width_exp(cmd_widen_in, 1'b0), uop_vs2_sew);
          // ready comes back with the final beat and not before
          check_bit("cmd_ready", k == nb - 1, cmd_ready);
        end
        k++;
        if (k == flush_at) begin
          @(posedge CLK);
          #5;
          flush = 1'b1;
          @(posedge CLK);
          #5;
          flush = 1'b0;
          @(negedge CLK);
          check_bit("uop_valid", 1'b0, uop_valid);
          check_bit("cmd_ready", 1'b1, cmd_ready);
          $display("cmd %0d flushed after %0d beats, %0d errors", v, k, errors - err0);
          return;
        end
      end
    end while (!cmd_ready);
    if (k != nb) begin
      report_failure($sformatf("command %0d gave %0d beats instead of %0d", v, k, nb));
    end
    $display("cmd %0d vl %0d: %0d beats, %0d errors", v, cmd_vl, k, errors - err0);
  endtask

  // every beat seen owes one credit back after its delay
  always @(negedge CLK) begin
    if (nRST && uop_valid) begin
      ret_delay = cur_random ? int'($unsigned($random(seed)) % (RAND_MAX_D + 1))
                             : cur_delay;
      due_q.push_back(cycle + ret_delay);
      outstanding++;
      if (outstanding > vec_cfg_pkg::INIT_CREDITS) begin
        report_failure("more beats outstanding than the execute side has credits");
      end
    end
  end

  // at most one credit per cycle, earliest due first found
  always @(posedge CLK) begin
    if (credit_return) begin
      outstanding--;
    end
    #5;
    q_found = 1'b0;
    for (int i = 0; i < due_q.size(); i++) begin
      if (!q_found && due_q[i] <= cycle) begin
        q_found = 1'b1;
        q_idx   = i;
      end
    end
    if (q_found) begin
      due_q.delete(q_idx);
    end
    credit_return = q_found;
  end

  always @(posedge CLK) begin
    cycle++;
    if (cycle > limit) begin
      $display("DUT stopped issuing beats, run halted after %0d cycles", cycle);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    CLK           = 1'b0;
    nRST          = 1'b0;
    cmd_valid     = 1'b0;
    cmd_vs2_src   = vec_uop_pkg::VS2_SRC_NORMAL;
    cmd_vd_src    = vec_uop_pkg::VD_SRC_NORMAL;
    cmd_widen     = 1'b0;
    cmd_widen_in  = 1'b0;
    cmd_narrow    = 1'b0;
    cmd_vm        = 1'b0;
    cmd_imm5      = '0;
    cmd_xs1       = '0;
    cmd_vl        = '0;
    cmd_sew       = vec_cfg_pkg::SEW8;
    v0_mask       = '0;
    credit_return = 1'b0;
    flush         = 1'b0;
    errors        = 0;
    checks        = 0;
    cycle         = 0;
    outstanding   = 0;
    cur_delay     = 0;
    cur_random    = 1'b0;
    seed          = 79;
    $readmemh("test/decode_vectors.txt", vec_mem);
    n_cmds = 0;
    while (n_cmds < MAX_CMDS && vec_mem[n_cmds*NW] !== 'x) n_cmds++;
    // reset, the two cycles after it, every line, then the flush pair
    limit = RST_CYCLES + 4;
    for (int v = 0; v < n_cmds; v++) limit += run_budget(v);
    limit += 2 * run_budget(0);
    repeat (RST_CYCLES) @(posedge CLK);
    #5;
    nRST = 1'b1;
    @(negedge CLK);
    check_bit("uop_valid", 1'b0, uop_valid);
    check_bit("uop_last", 1'b0, uop_last);
    check_bit("cmd_ready", 1'b0, cmd_ready);
    @(negedge CLK);
    check_bit("cmd_ready", 1'b1, cmd_ready);
    $display("reset: %0d errors", errors);
    if (n_cmds == 0) begin
      report_failure("no commands could be read from the vector file");
    end
    for (int v = 0; v < n_cmds; v++) run_cmd(v, -1);
    // cut the first command short, then check it still runs clean
    run_cmd(0, 3);
    run_cmd(0, -1);
    $display("%0d commands, %0d checks, %0d errors", n_cmds + 2, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/decode_vectors.txt
// vs2_src vd_src widen widen_in narrow vm imm5 xs1 vl sew v0_mask credit_delay
// all hex, credit_delay ff means a random delay of 0 to 7 cycles per beat
0 0 0 0 0 0 00 00000000 20 0 00000000 00
1 2 0 0 0 0 00 00000005 08 0 00000000 01
2 3 0 0 0 0 1f 00000000 07 1 00000000 00
3 4 0 0 0 0 00 00000000 09 2 00000000 02
4 1 0 0 0 0 00 00000000 06 0 00000000 00
5 0 0 0 0 0 00 00000000 05 1 00000000 00
1 3 0 0 0 0 0a fffffffe 0b 0 00000000 00
0 0 0 0 0 1 00 00000000 0d 0 a5c3f00f 00
0 0 1 0 0 0 00 00000000 04 0 00000000 00
0 0 1 1 0 0 00 00000000 04 1 00000000 00
0 0 1 1 0 0 00 00000000 04 2 00000000 00
0 0 0 0 1 0 00 00000000 04 0 00000000 00
0 0 0 0 1 0 00 00000000 04 1 00000000 00
0 0 0 0 1 0 00 00000000 04 2 00000000 00
0 0 0 1 0 0 00 00000000 03 0 00000000 00
0 0 0 0 0 0 00 00000000 00 0 00000000 00
3 4 0 0 0 1 00 00000000 20 2 0f0f5555 09
4 2 0 0 0 1 15 00000033 1f 1 deadbeef ff
0 0 0 0 0 0 00 00000000 01 0 00000000 05

//--- files.f
source/vec_cfg_pkg.sv
source/vec_uop_pkg.sv
source/elem_sequencer.sv
source/offset_gen.sv
source/width_calc.sv
source/lane_enable.sv
source/issue_reg.sv
source/vec_decode_top.sv
test/tb_vec_decode.sv
